//--- include/i2c_bridge_config.svh
// Buffer depths, SCL pacing and reset device address of the I2C bridge
`ifndef I2C_BRIDGE_CONFIG_SVH
`define I2C_BRIDGE_CONFIG_SVH

// Largest number of data bytes in one write command
`define WRITE_BUF_DEPTH 32

// Largest length accepted by a read command
`define READ_BUF_DEPTH 32

// clk cycles per SCL half period
`define SCL_HALF_PERIOD 8

// 7-bit device address after reset
`define RESET_DEV_ADDR 7'h50

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the bridge testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_i2c_bridge \
    -Mdir obj_dir -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "Regression passed" &&
echo "simulation status: PASS" ||
{
    echo "simulation status: FAIL"
    exit 1
}

//--- sources.f
+incdir+include
verilog/bridge_cmd_pkg.sv
verilog/i2c_bus_pkg.sv
verilog/i2c_handler.sv
verilog/i2c_byte_master.sv
verilog/i2c_bridge_top.sv
verification/i2c_eeprom_model.sv
verification/tb_i2c_bridge.sv

//--- verification/i2c_bridge_vectors.txt
// Record: op, byte count, frame bytes, upload count, then source and data per upload beat
// An op of 00 ends the list
05 0A 00 10 11 22 33 44 55 66 77 88 00
06 04 00 10 00 08 08 06 11 06 22 06 33 06 44 06 55 06 66 06 77 06 88
05 22 00 40
80 81 82 83 84 85 86 87 88 89 8A 8B 8C 8D 8E 8F 90 91 92 93 94 95 96 97 98 99 9A 9B 9C 9D 9E 9F
00
06 04 00 40 00 20 20
06 80 06 81 06 82 06 83 06 84 06 85 06 86 06 87 06 88 06 89 06 8A 06 8B 06 8C 06 8D 06 8E 06 8F
06 90 06 91 06 92 06 93 06 94 06 95 06 96 06 97 06 98 06 99 06 9A 06 9B 06 9C 06 9D 06 9E 06 9F
04 01 23 00
05 03 00 05 AA 01 07 01
04 01 50 00
06 04 00 10 00 02 02 06 11 06 22
05 02 00 10 00
06 03 00 10 00 00
06 04 00 10 00 00 00
06 04 00 10 00 21 00
06 04 00 13 00 04 04 06 44 06 55 06 66 06 77
00

//--- verification/i2c_eeprom_model.sv
// Behavioral I2C register-memory slave with 8-bit index and auto-increment
`timescale 1ns/1ps

module i2c_eeprom_model #(
    parameter logic [6:0] DEV_ADDR = 7'h50
) (
    input  logic scl,
    input  logic sda,
    output logic sda_pull
);

    typedef enum int {M_IDLE, M_ADDR, M_REG_HI, M_REG_LO, M_WDATA, M_IGNORE} mstate_e;

    mstate_e    state  = M_IDLE;
    logic [7:0] mem [256];
    logic [7:0] sr     = '0;
    logic [7:0] ptr    = '0;
    int         bit_n  = 0;
    logic       in_ack = 1'b0;
    logic       tx     = 1'b0;
    logic       go_tx  = 1'b0;
    logic       ack    = 1'b0;

    initial begin
        sda_pull = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i) ^ 8'hc3;
        end
    end

    // Start or repeated start, the register pointer survives
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            state    = M_ADDR;
            bit_n    = 0;
            in_ack   = 1'b0;
            tx       = 1'b0;
            go_tx    = 1'b0;
            sda_pull = 1'b0;
        end
    end

    // Stop
    always @(posedge sda) begin
        if (scl === 1'b1) begin
            state    = M_IDLE;
            tx       = 1'b0;
            in_ack   = 1'b0;
            sda_pull = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (tx) begin
            // Master ACK slot after a sent byte
            if (bit_n == 9) begin
                if (sda) begin
                    tx    = 1'b0;
                    state = M_IDLE;
                end else begin
                    ptr   = ptr + 8'd1;
                    bit_n = 0;
                end
            end
        end else if (state != M_IDLE && !in_ack) begin
            sr    = {sr[6:0], sda};
            bit_n = bit_n + 1;
        end
    end

    always @(negedge scl) begin
        if (tx) begin
            if (bit_n < 8) begin
                sda_pull = !mem[ptr][7 - bit_n];
                bit_n    = bit_n + 1;
            end else begin
                sda_pull = 1'b0;
                bit_n    = 9;
            end
        end else if (in_ack) begin
            in_ack   = 1'b0;
            sda_pull = 1'b0;
            if (go_tx) begin
                go_tx    = 1'b0;
                tx       = 1'b1;
                sda_pull = !mem[ptr][7];
                bit_n    = 1;
            end
        end else if (bit_n == 8 && state != M_IDLE) begin
            bit_n  = 0;
            in_ack = 1'b1;
            ack    = 1'b1;
            case (state)
                M_ADDR: begin
                    if (sr[7:1] != DEV_ADDR) begin
                        ack   = 1'b0;
                        state = M_IGNORE;
                    end else if (sr[0]) begin
                        go_tx = 1'b1;
                    end else begin
                        state = M_REG_HI;
                    end
                end
                M_REG_HI: state = M_REG_LO;
                M_REG_LO: begin
                    ptr   = sr;
                    state = M_WDATA;
                end
                M_WDATA: begin
                    mem[ptr] = sr;
                    ptr      = ptr + 8'd1;
                end
                default: ack = 1'b0;
            endcase
            sda_pull = ack;
        end
    end

endmodule

//--- verification/tb_i2c_bridge.sv
// Vector-driven testbench for the I2C bridge with an EEPROM bus model
`timescale 1ns/1ps
`include "i2c_bridge_config.svh"

module tb_i2c_bridge;

    localparam int VEC_BYTES  = 1024;
    localparam int WAIT_LIMIT = 200000;

    logic                         clk = 1'b0;
    logic                         rst_n;
    logic                         cmd_valid;
    logic                         cmd_ready;
    bridge_cmd_pkg::cmd_beat_t    cmd;
    logic                         upload_valid;
    logic                         upload_ready = 1'b0;
    bridge_cmd_pkg::upload_beat_t upload;
    logic                         scl;
    logic                         sda_oe;
    logic                         sda_pull;
    logic                         sda;

    logic [7:0]                   vec [VEC_BYTES];
    logic [7:0]                   frame [64];
    logic [31:0]                  lfsr_state = 32'h34a3_537e;
    bridge_cmd_pkg::upload_beat_t got_q [$];
    bridge_cmd_pkg::upload_beat_t held_beat;
    logic                         held = 1'b0;
    int                           scl_falls = 0;
    int                           error_count = 0;

    // Open-drain SDA is low when either side pulls
    assign sda = !(sda_oe || sda_pull);

    i2c_bridge_top dut (
        .clk(clk), .rst_n(rst_n),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd(cmd),
        .upload_valid(upload_valid), .upload_ready(upload_ready), .upload(upload),
        .scl(scl), .sda_oe(sda_oe), .sda_in(sda)
    );

    i2c_eeprom_model #(.DEV_ADDR(`RESET_DEV_ADDR)) u_eeprom (
        .scl(scl), .sda(sda), .sda_pull(sda_pull)
    );

    always #4 clk = ~clk;

    always @(negedge scl) scl_falls++;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic report_failure(input string what);
        error_count++;
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual)
        else report_failure($sformatf("MISMATCH %s: expected 0x%0h, actual 0x%0h",
                                      name, expected, actual));
    endtask

    // Frame rules decide whether a record may touch the bus
    function automatic logic bus_expected(input logic [7:0] op, input int count);
        int len;
        len = (count == 4) ? int'({frame[2], frame[3]}) : 0;
        case (op)
            8'h05:   bus_expected = (count >= 3) && (count <= `WRITE_BUF_DEPTH + 2);
            8'h06:   bus_expected = (count == 4) && (len >= 1) && (len <= `READ_BUF_DEPTH);
            default: bus_expected = 1'b0;
        endcase
    endfunction

    // ==================================================
    // Upload sink with random back-pressure
    // ==================================================
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (held) begin
                assert (upload_valid && upload == held_beat)
                else report_failure("upload beat changed while waiting to be accepted");
            end
            upload_ready = lfsr_state[0];
            lfsr_state   = lfsr_next(lfsr_state);
            // The beat seen now is taken at the next rising edge when ready is high
            if (upload_valid && upload_ready) got_q.push_back(upload);
            held         = upload_valid && !upload_ready;
            held_beat    = upload;
        end
    end

    task automatic send_frame(input logic [7:0] op, input int count);
        int waited;
        for (int i = 0; i < count; i++) begin
            cmd_valid = 1'b1;
            cmd.op    = bridge_cmd_pkg::cmd_op_e'(op);
            cmd.data  = frame[i];
            cmd.last  = (i == count - 1);
            waited    = 0;
            while (!cmd_ready) begin
                @(negedge clk);
                waited++;
                if (waited > WAIT_LIMIT) report_failure("timeout while a command beat waited");
            end
            @(negedge clk);
        end
        cmd_valid = 1'b0;
    endtask

    task automatic wait_command_done();
        int waited;
        waited = 0;
        while (!cmd_ready) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) report_failure("timeout waiting for a command to end");
        end
        // Room for any stray bus start to show up
        repeat (20) @(negedge clk);
    endtask

    initial begin
        int pos;
        int rec;
        int op;
        int count;
        int exp_count;
        int falls_before;
        logic [7:0] exp_src [64];
        logic [7:0] exp_data [64];
        bridge_cmd_pkg::upload_beat_t b;

        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        $readmemh("verification/i2c_bridge_vectors.txt", vec);
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_value("reset cmd_ready", 1, cmd_ready);
        check_value("reset upload_valid", 0, upload_valid);
        check_value("reset scl", 1, scl);
        check_value("reset sda_oe", 0, sda_oe);

        pos = 0;
        rec = 0;
        while (vec[pos] != 8'h00) begin
            op    = vec[pos];
            count = vec[pos + 1];
            pos   = pos + 2;
            for (int i = 0; i < count; i++) frame[i] = vec[pos + i];
            pos       = pos + count;
            exp_count = vec[pos];
            pos       = pos + 1;
            for (int i = 0; i < exp_count; i++) begin
                exp_src[i]  = vec[pos + 2 * i];
                exp_data[i] = vec[pos + 2 * i + 1];
            end
            pos = pos + 2 * exp_count;

            got_q.delete();
            falls_before = scl_falls;
            send_frame(8'(op), count);
            wait_command_done();

            check_value($sformatf("record %0d upload count", rec), exp_count, got_q.size());
            for (int i = 0; i < exp_count; i++) begin
                b = got_q[i];
                check_value($sformatf("record %0d beat %0d source", rec, i),
                            exp_src[i], int'(b.source));
                check_value($sformatf("record %0d beat %0d data", rec, i), exp_data[i], b.data);
                check_value($sformatf("record %0d beat %0d last", rec, i),
                            (i == exp_count - 1), b.last);
            end
            if (!bus_expected(8'(op), count))
                check_value($sformatf("record %0d SCL falls", rec), falls_before, scl_falls);
            rec++;
        end

        if (error_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            report_failure("errors were recorded during the run");
        end
    end

endmodule

//--- verilog/bridge_cmd_pkg.sv
// Host-side types: command opcodes, command beat and upload beat
package bridge_cmd_pkg;

    // Frame opcodes, OP_STATUS only appears on the upload stream
    typedef enum logic [7:0] {
        OP_CONFIG = 8'h04,
        OP_WRITE  = 8'h05,
        OP_READ   = 8'h06,
        OP_STATUS = 8'h07
    } cmd_op_e;

    // One byte of a command frame
    typedef struct packed {
        cmd_op_e    op;
        logic [7:0] data;
        logic       last;
    } cmd_beat_t;

    // One byte returned to the host
    typedef struct packed {
        cmd_op_e    source;
        logic [7:0] data;
        logic       last;
    } upload_beat_t;

endpackage

//--- verilog/i2c_bridge_top.sv
// Top level of the command-to-I2C bridge, handler plus byte master
`timescale 1ns/1ps

module i2c_bridge_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cmd_valid,
    output logic                         cmd_ready,
    input  bridge_cmd_pkg::cmd_beat_t    cmd,
    output logic                         upload_valid,
    input  logic                         upload_ready,
    output bridge_cmd_pkg::upload_beat_t upload,
    output logic                         scl,
    output logic                         sda_oe,
    input  logic                         sda_in
);

    logic                  req_valid;
    logic                  req_ready;
    i2c_bus_pkg::i2c_req_t req;
    logic                  rsp_valid;
    i2c_bus_pkg::i2c_rsp_t rsp;

    i2c_handler u_handler (
        .clk(clk), .rst_n(rst_n),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd(cmd),
        .upload_valid(upload_valid), .upload_ready(upload_ready), .upload(upload),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .rsp_valid(rsp_valid), .rsp(rsp)
    );

    i2c_byte_master u_master (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .rsp_valid(rsp_valid), .rsp(rsp),
        .scl(scl), .sda_oe(sda_oe), .sda_in(sda_in)
    );

endmodule

//--- verilog/i2c_bus_pkg.sv
// Bus-side types: operation enum, register request and response
package i2c_bus_pkg;

    typedef enum logic {
        BUS_WRITE = 1'b0,
        BUS_READ  = 1'b1
    } i2c_op_e;

    // Single-byte register transfer with a 16-bit register address
    typedef struct packed {
        i2c_op_e     op;
        logic [6:0]  dev_addr;
        logic [15:0] reg_addr;
        logic [7:0]  wdata;
    } i2c_req_t;

    // Read byte and folded ACK result
    typedef struct packed {
        logic [7:0] rdata;
        logic       nak;
    } i2c_rsp_t;

endpackage

//--- verilog/i2c_byte_master.sv
// Bit-level I2C master doing one 16-bit-addressed register byte write or read
`timescale 1ns/1ps
`include "i2c_bridge_config.svh"

module i2c_byte_master (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  i2c_bus_pkg::i2c_req_t req,
    output logic                  rsp_valid,
    output i2c_bus_pkg::i2c_rsp_t rsp,
    output logic                  scl,
    output logic                  sda_oe,
    input  logic                  sda_in
);

    localparam int HALF  = `SCL_HALF_PERIOD;
    localparam int CNT_W = $clog2(HALF + 1);

    typedef enum logic [3:0] {
        PH_IDLE, PH_START, PH_ADDR, PH_REG_HI, PH_REG_LO, PH_DATA,
        PH_RSTART, PH_RADDR, PH_RDATA, PH_MNAK, PH_STOP
    } phase_e;

    phase_e                phase;
    i2c_bus_pkg::i2c_req_t req_q;
    logic [CNT_W-1:0]      cnt;
    logic                  half;     // high half of the SCL period
    logic [3:0]            bit_cnt;
    logic [7:0]            shifter;
    logic [7:0]            rx;
    logic                  nak_acc;

    logic                  mid;
    logic                  tick;
    logic                  wr_byte;
    logic                  last_bit;

    assign req_ready = (phase == PH_IDLE);
    assign mid       = (cnt == CNT_W'(HALF / 2 - 1));
    assign tick      = (cnt == CNT_W'(HALF - 1));
    assign wr_byte   = phase inside {PH_ADDR, PH_REG_HI, PH_REG_LO, PH_DATA, PH_RADDR};

    always_comb begin
        case (phase)
            PH_RDATA: last_bit = (bit_cnt == 4'd7);
            PH_MNAK:  last_bit = 1'b1;
            default:  last_bit = (bit_cnt == 4'd8);
        endcase
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) req_q <= req;
    end

    // ==================================================
    // Bus sequencer
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= PH_IDLE;
            cnt       <= '0;
            half      <= 1'b1;
            bit_cnt   <= '0;
            shifter   <= '0;
            rx        <= '0;
            nak_acc   <= 1'b0;
            scl       <= 1'b1;
            sda_oe    <= 1'b0;
            rsp_valid <= 1'b0;
            rsp       <= '0;
        end else begin
            rsp_valid <= 1'b0;
            if (phase == PH_IDLE) begin
                cnt <= '0;
                if (req_valid) begin
                    phase   <= PH_START;
                    half    <= 1'b1;
                    nak_acc <= 1'b0;
                end
            end else begin
                cnt <= tick ? '0 : cnt + 1'b1;

                // SDA moves mid-half, clear of the SCL edges
                if (mid) begin
                    case (phase)
                        PH_START:  sda_oe <= 1'b1;
                        PH_RSTART: sda_oe <= half;
                        PH_STOP:   sda_oe <= !half;
                        default: begin
                            if (!half) sda_oe <= wr_byte && (bit_cnt < 4'd8) && !shifter[7];
                        end
                    endcase
                end

                if (tick && !half) begin
                    scl  <= 1'b1;
                    half <= 1'b1;
                end else if (tick) begin
                    scl     <= 1'b0;
                    half    <= 1'b0;
                    bit_cnt <= bit_cnt + 4'd1;
                    shifter <= {shifter[6:0], 1'b0};
                    // Sample at the end of SCL high
                    if (wr_byte && bit_cnt == 4'd8) nak_acc <= nak_acc | sda_in;
                    if (phase == PH_RDATA) rx <= {rx[6:0], sda_in};
                    case (phase)
                        PH_START: begin
                            phase   <= PH_ADDR;
                            bit_cnt <= '0;
                            shifter <= {req_q.dev_addr, 1'b0};
                        end
                        PH_RSTART: begin
                            phase   <= PH_RADDR;
                            bit_cnt <= '0;
                            shifter <= {req_q.dev_addr, 1'b1};
                        end
                        PH_STOP: begin
                            scl       <= 1'b1;
                            half      <= 1'b1;
                            phase     <= PH_IDLE;
                            rsp_valid <= 1'b1;
                            rsp       <= '{rdata: rx, nak: nak_acc};
                        end
                        default: begin
                            if (last_bit) begin
                                bit_cnt <= '0;
                                case (phase)
                                    PH_ADDR: begin
                                        phase   <= PH_REG_HI;
                                        shifter <= req_q.reg_addr[15:8];
                                    end
                                    PH_REG_HI: begin
                                        phase   <= PH_REG_LO;
                                        shifter <= req_q.reg_addr[7:0];
                                    end
                                    PH_REG_LO: begin
                                        phase   <= (req_q.op == i2c_bus_pkg::BUS_READ) ?
                                                   PH_RSTART : PH_DATA;
                                        shifter <= req_q.wdata;
                                    end
                                    PH_RADDR: phase <= PH_RDATA;
                                    PH_RDATA: phase <= PH_MNAK;
                                    default:  phase <= PH_STOP;
                                endcase
                            end
                        end
                    endcase
                end
            end
        end
    end

    a_sda_scl_low: assert property (@(posedge clk) disable iff (!rst_n)
        (sda_oe != $past(sda_oe)) && !(phase inside {PH_START, PH_RSTART, PH_STOP})
        |-> !scl && !$past(scl));

endmodule

//--- verilog/i2c_handler.sv
// Command parser, write and read buffers, transfer sequencer and upload engine
`timescale 1ns/1ps
`include "i2c_bridge_config.svh"

module i2c_handler (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cmd_valid,
    output logic                         cmd_ready,
    input  bridge_cmd_pkg::cmd_beat_t    cmd,
    output logic                         upload_valid,
    input  logic                         upload_ready,
    output bridge_cmd_pkg::upload_beat_t upload,
    output logic                         req_valid,
    input  logic                         req_ready,
    output i2c_bus_pkg::i2c_req_t        req,
    input  logic                         rsp_valid,
    input  i2c_bus_pkg::i2c_rsp_t        rsp
);

    localparam int IDX_W = $clog2(`WRITE_BUF_DEPTH + 3);
    localparam int PTR_W = $clog2(`WRITE_BUF_DEPTH + `READ_BUF_DEPTH + 1);
    localparam int WA_W  = $clog2(`WRITE_BUF_DEPTH);
    localparam int RA_W  = $clog2(`READ_BUF_DEPTH);

    typedef enum logic [2:0] {
        ST_IDLE, ST_PARSE, ST_DISCARD, ST_WRITE, ST_READ, ST_UPLOAD, ST_STATUS
    } state_e;

    state_e                  state;
    bridge_cmd_pkg::cmd_op_e frame_op;
    logic [IDX_W-1:0]        byte_idx;
    logic [6:0]              dev_addr;
    logic [15:0]             reg_addr;
    logic [7:0]              len_hi;
    logic [PTR_W-1:0]        len;
    logic [PTR_W-1:0]        ptr;
    logic                    busy;
    logic [7:0]              wbuf [`WRITE_BUF_DEPTH];
    logic [7:0]              rbuf [`READ_BUF_DEPTH];

    logic                    parsing;
    logic                    beat_fire;
    logic [IDX_W-1:0]        idx;
    logic [IDX_W-1:0]        widx;
    bridge_cmd_pkg::cmd_op_e op;
    logic [15:0]             read_len;
    logic                    frame_bad;
    logic                    frame_ok;

    // ==================================================
    // Frame decode
    // ==================================================
    assign parsing   = (state == ST_IDLE) || (state == ST_PARSE);
    assign cmd_ready = parsing || (state == ST_DISCARD);
    assign beat_fire = cmd_valid && cmd_ready;
    // First beat of a frame has index 0 and fixes the frame opcode
    assign idx       = (state == ST_IDLE) ? '0 : byte_idx;
    assign op        = (state == ST_IDLE) ? cmd.op : frame_op;
    assign widx      = idx - IDX_W'(2);
    assign read_len  = {len_hi, cmd.data};

    always_comb begin
        frame_bad = (cmd.op != op);
        frame_ok  = 1'b0;
        case (op)
            bridge_cmd_pkg::OP_CONFIG: frame_ok = 1'b1;
            bridge_cmd_pkg::OP_WRITE:  frame_ok = (idx >= IDX_W'(2));
            bridge_cmd_pkg::OP_READ:   frame_ok = (idx == IDX_W'(3)) && (read_len != 16'd0) &&
                                                  (read_len <= 16'(`READ_BUF_DEPTH));
            default:                   frame_bad = 1'b1;
        endcase
        // Too many bytes for the opcode
        if (op == bridge_cmd_pkg::OP_CONFIG && idx != '0)
            frame_bad = 1'b1;
        if (op == bridge_cmd_pkg::OP_WRITE && idx >= IDX_W'(`WRITE_BUF_DEPTH + 2))
            frame_bad = 1'b1;
        if (op == bridge_cmd_pkg::OP_READ && idx > IDX_W'(3))
            frame_bad = 1'b1;
    end

    assign req.op       = (state == ST_READ) ? i2c_bus_pkg::BUS_READ : i2c_bus_pkg::BUS_WRITE;
    assign req.dev_addr = dev_addr;
    assign req.reg_addr = reg_addr;
    assign req.wdata    = wbuf[ptr[WA_W-1:0]];

    always_ff @(posedge clk) begin
        if (beat_fire && parsing && op == bridge_cmd_pkg::OP_WRITE && !frame_bad &&
            idx >= IDX_W'(2))
            wbuf[widx[WA_W-1:0]] <= cmd.data;
        if (rsp_valid && state == ST_READ)
            rbuf[ptr[RA_W-1:0]] <= rsp.rdata;
    end

    // ==================================================
    // Sequencer
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            frame_op     <= bridge_cmd_pkg::OP_CONFIG;
            byte_idx     <= '0;
            dev_addr     <= `RESET_DEV_ADDR;
            reg_addr     <= '0;
            len_hi       <= '0;
            len          <= '0;
            ptr          <= '0;
            busy         <= 1'b0;
            req_valid    <= 1'b0;
            upload_valid <= 1'b0;
            upload       <= '0;
        end else begin
            case (state)
                ST_IDLE, ST_PARSE: begin
                    if (beat_fire) begin
                        frame_op <= op;
                        byte_idx <= idx + 1'b1;
                        ptr      <= '0;
                        if (idx == IDX_W'(0)) reg_addr[15:8] <= cmd.data;
                        if (idx == IDX_W'(1)) reg_addr[7:0]  <= cmd.data;
                        if (idx == IDX_W'(2)) len_hi         <= cmd.data;
                        if (!cmd.last) begin
                            state <= frame_bad ? ST_DISCARD : ST_PARSE;
                        end else begin
                            state <= ST_IDLE;
                            if (!frame_bad && frame_ok) begin
                                case (op)
                                    bridge_cmd_pkg::OP_WRITE: begin
                                        len   <= PTR_W'(idx - 1'b1);
                                        state <= ST_WRITE;
                                    end
                                    bridge_cmd_pkg::OP_READ: begin
                                        len   <= PTR_W'(read_len);
                                        state <= ST_READ;
                                    end
                                    default: dev_addr <= cmd.data[6:0];
                                endcase
                            end
                        end
                    end
                end
                ST_DISCARD: begin
                    if (beat_fire && cmd.last) state <= ST_IDLE;
                end
                ST_WRITE, ST_READ: begin
                    if (!busy && !req_valid) req_valid <= 1'b1;
                    if (req_valid && req_ready) begin
                        req_valid <= 1'b0;
                        busy      <= 1'b1;
                    end
                    // One register address and buffer slot per transfer
                    if (rsp_valid) begin
                        busy     <= 1'b0;
                        ptr      <= ptr + 1'b1;
                        reg_addr <= reg_addr + 16'd1;
                        if (rsp.nak) begin
                            state <= ST_STATUS;
                        end else if (ptr + 1'b1 == len) begin
                            ptr   <= '0;
                            state <= (state == ST_READ) ? ST_UPLOAD : ST_IDLE;
                        end
                    end
                end
                ST_UPLOAD: begin
                    if (!upload_valid || upload_ready) begin
                        if (upload_valid && upload.last) begin
                            upload_valid <= 1'b0;
                            state        <= ST_IDLE;
                        end else begin
                            upload_valid  <= 1'b1;
                            upload.source <= bridge_cmd_pkg::OP_READ;
                            upload.data   <= rbuf[ptr[RA_W-1:0]];
                            upload.last   <= (ptr + 1'b1 == len);
                            ptr           <= ptr + 1'b1;
                        end
                    end
                end
                default: begin
                    // Device NAK reported as a single status byte
                    if (!upload_valid) begin
                        upload_valid <= 1'b1;
                        upload       <= '{source: bridge_cmd_pkg::OP_STATUS, data: 8'h01,
                                          last: 1'b1};
                    end else if (upload_ready) begin
                        upload_valid <= 1'b0;
                        state        <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    a_upload_stable: assert property (@(posedge clk) disable iff (!rst_n)
        upload_valid && !upload_ready |=> upload_valid && $stable(upload));

    // A new request only appears while the bus master is idle
    a_one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(req_valid) |-> req_ready);

endmodule
